// ==== files.f ====
snes_bus_pkg.sv
mem_pkg.sv
snes_bus_sampler.sv
snes_addr_map.sv
rom_arbiter.sv
rom_bus_drive.sv
snes_mem_ctrl.sv
tb_snes_mem_ctrl.sv

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  typedef logic [23:0] rom_addr_t;

  // one request from the MCU or the DMA engine
  typedef struct packed {
    logic      rrq;    // one-cycle read pulse
    logic      wrq;    // one-cycle write pulse
    rom_addr_t addr;
    logic [15:0] data;
    logic      word;   // DMA only, MCU is always byte wide
  } mem_req_t;

  typedef enum logic [2:0] {
    st_idle   = 3'd0,
    st_mcu_rd = 3'd1,
    st_mcu_wr = 3'd2,
    st_dma_rd = 3'd3,
    st_dma_wr = 3'd4,
    st_end    = 3'd5
  } arb_state_e;

  // who drives the ROM address lines
  typedef enum logic [1:0] {
    own_snes = 2'd0,
    own_mcu  = 2'd1,
    own_dma  = 2'd2
  } owner_e;

  typedef struct packed {
    owner_e      owner;
    logic        write;      // granted access is a write
    logic        we_active;  // write strobe phase
    rom_addr_t   addr;
    logic [15:0] data;
    logic        word;
  } mem_grant_t;

endpackage

`default_nettype wire

// ==== rom_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rom_arbiter import snes_bus_pkg::*, mem_pkg::*; #(
  parameter int rom_cycle_len = 7
) (
  input  wire            CLK2,
  input  wire            SNES_reset_strobe,
  input  wire snes_evt_t evt,
  input  wire            rom_hit,
  input  wire mem_req_t  mcu_req,
  input  wire mem_req_t  dma_req,
  input  wire [7:0]      rom_byte,
  input  wire [15:0]     rom_word,
  output logic           mcu_rdy,
  output logic [7:0]     mcu_rdata,
  output logic           dma_rdy,
  output logic [15:0]    dma_rdata,
  output mem_grant_t     grant
);

  localparam int dly_w = (rom_cycle_len > 1) ? $clog2(rom_cycle_len + 1) : 1;

  arb_state_e       state;
  arb_state_e       pick;
  owner_e           owner;
  logic [dly_w-1:0] delay;
  logic             free_strobe;
  logic             free_slot;
  mem_req_t         req [2];     // 0 = MCU, 1 = DMA
  mem_req_t         lat [2];
  mem_req_t         cur;
  logic             rd_pend [2];
  logic             wr_pend [2];
  logic             rdy [2];

  assign req[0]  = mcu_req;
  assign req[1]  = dma_req;
  assign mcu_rdy = rdy[0];
  assign dma_rdy = rdy[1];

  ////////////////////////////////////////
  // free slots on the ROM bus
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= evt.cycle_start & ~rom_hit; // console cycle not touching ROM
    end
  end

  assign free_slot = evt.pulse_end | free_strobe;

  ////////////////////////////////////////
  // request capture, same for both requesters
  for (genvar i = 0; i < 2; i++) begin : g_req
    localparam owner_e me = owner_e'(i + 1);

    always_ff @(posedge CLK2) begin
      if (SNES_reset_strobe) begin
        rd_pend[i] <= 1'b0;
        wr_pend[i] <= 1'b0;
        rdy[i]     <= 1'b1;
      end else if (req[i].rrq | req[i].wrq) begin
        rd_pend[i] <= req[i].rrq;
        wr_pend[i] <= ~req[i].rrq;   // read wins if both pulse
        rdy[i]     <= 1'b0;
      end else if (state == st_end && owner == me) begin
        rd_pend[i] <= 1'b0;
        wr_pend[i] <= 1'b0;
        rdy[i]     <= 1'b1;
      end
    end

    always_ff @(posedge CLK2) begin
      if (req[i].rrq | req[i].wrq) begin
        lat[i] <= req[i];
      end
    end
  end

  // MCU before DMA, reads before writes
  always_comb begin
    pick = st_idle;
    if (rd_pend[0]) begin
      pick = st_mcu_rd;
    end else if (wr_pend[0]) begin
      pick = st_mcu_wr;
    end else if (rd_pend[1]) begin
      pick = st_dma_rd;
    end else if (wr_pend[1]) begin
      pick = st_dma_wr;
    end
  end

  ////////////////////////////////////////
  // memory cycle FSM
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state <= st_idle;
      owner <= own_snes;
      delay <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (free_slot && pick != st_idle) begin
            state <= pick;
            delay <= dly_w'(rom_cycle_len);
            if (pick == st_mcu_rd || pick == st_mcu_wr) begin
              owner <= own_mcu;
            end else begin
              owner <= own_dma;
            end
          end
        end
        st_mcu_rd, st_mcu_wr, st_dma_rd, st_dma_wr: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= st_end;  // rom_cycle_len+1 cycles done
          end
        end
        st_end: begin
          state <= st_idle;
          owner <= own_snes;
        end
        default: begin
          state <= st_idle;
          owner <= own_snes;
        end
      endcase
    end
  end

  // read data, last sample of the access wins
  always_ff @(posedge CLK2) begin
    if (state == st_mcu_rd) begin
      mcu_rdata <= rom_byte;
    end
    if (state == st_dma_rd) begin
      dma_rdata <= lat[1].addr[0] ? rom_word : {rom_word[7:0], rom_word[15:8]};
    end
  end

  always_comb begin
    cur             = (owner == own_dma) ? lat[1] : lat[0];
    grant.owner     = owner;
    grant.write     = (owner == own_mcu) ? wr_pend[0] : (owner == own_dma) & wr_pend[1];
    grant.we_active = (state == st_mcu_wr) || (state == st_dma_wr);
    grant.addr      = cur.addr;
    grant.data      = cur.data;
    grant.word      = (owner == own_dma) & cur.word; // MCU is byte only
  end

endmodule

`default_nettype wire

// ==== rom_bus_drive.sv ====
`timescale 1ns/1ns
`default_nettype none

module rom_bus_drive import snes_bus_pkg::*, mem_pkg::*; (
  input  wire mem_grant_t grant,
  input  wire map_res_t   map,
  input  wire snes_evt_t  evt,
  input  wire [7:0]       snes_data,
  input  wire [15:0]      rom_data_in,
  output logic [22:0]     rom_addr,
  output logic            rom_bhe,
  output logic            rom_ble,
  output logic            rom_we,
  output logic [15:0]     rom_data_out,
  output logic            rom_data_oe,
  output logic [7:0]      rom_byte,
  output logic [15:0]     rom_word,
  output logic [7:0]      snes_data_out,
  output logic            snes_databus_oe,
  output logic            snes_databus_dir
);

  logic      req_own;
  rom_addr_t addr;
  logic      word;
  logic      console_wr;

  ////////////////////////////////////////
  // address mux and byte lanes
  assign req_own = (grant.owner != own_snes);
  assign addr    = req_own ? grant.addr : map.addr;
  assign word    = req_own & grant.word;

  assign rom_addr = addr[23:1];
  assign rom_bhe  = addr[0] & ~word;   // odd byte sits in the low lane
  assign rom_ble  = ~addr[0] & ~word;

  assign rom_byte = addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
  assign rom_word = rom_data_in;

  ////////////////////////////////////////
  // write path
  assign console_wr = map.is_saveram & ~evt.write;

  always_comb begin
    if (req_own) begin
      rom_we      = ~grant.we_active;
      rom_data_oe = grant.write;
      if (word) begin
        rom_data_out = {grant.data[7:0], grant.data[15:8]};
      end else begin
        rom_data_out = {grant.data[7:0], grant.data[7:0]};
      end
    end else begin
      rom_we       = ~(console_wr & evt.cpu_clk);  // strobe only in the data phase
      rom_data_oe  = console_wr;
      rom_data_out = {snes_data, snes_data};
    end
  end

  // console side
  assign snes_data_out    = rom_byte;
  assign snes_databus_oe  = ~(map.rom_hit & ~(evt.read & evt.write));
  assign snes_databus_dir = ~evt.read;  // 1 = FPGA to console

endmodule

`default_nettype wire

// ==== snes_addr_map.sv ====
`timescale 1ns/1ns
`default_nettype none

module snes_addr_map import snes_bus_pkg::*; (
  input  wire             CLK2,
  input  wire             SNES_reset_strobe,
  input  wire map_cfg_t   cfg,
  input  wire snes_addr_t snes_addr,
  input  wire             romsel,
  output map_res_t        res
);

  logic [7:0] bank;
  logic       lo_save;
  logic       hi_save;
  logic       is_saveram;
  logic       is_rom;
  snes_addr_t save_addr;
  snes_addr_t rom_addr;

  assign bank = snes_addr[23:16];

  // lorom: banks $70-$7d, lower 32k
  assign lo_save = (bank >= 8'h70) && (bank <= 8'h7d) && !snes_addr[15];
  // hirom: banks $20-$3f and $a0-$bf, $6000-$7fff
  assign hi_save = (bank[6:5] == 2'b01) && (snes_addr[15:13] == 3'b011);

  assign is_saveram = (cfg.mapper == lorom) ? lo_save : hi_save;
  assign is_rom     = !romsel && !is_saveram;

  always_comb begin
    if (cfg.mapper == lorom) begin
      save_addr = {4'b0, bank[4:0], snes_addr[14:0]};
      rom_addr  = {2'b0, bank[6:0], snes_addr[14:0]};
    end else begin
      save_addr = {6'b0, bank[4:0], snes_addr[12:0]};
      rom_addr  = {2'b0, snes_addr[21:0]};
    end
  end

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      res <= '0;
    end else begin
      if (is_saveram) begin
        res.addr <= 24'he00000 + (save_addr & cfg.saveram_mask); // save-RAM lives at $e00000
      end else begin
        res.addr <= rom_addr & cfg.rom_mask;
      end
      res.is_saveram <= is_saveram;
      res.is_rom     <= is_rom;
      res.rom_hit    <= is_rom | is_saveram;
    end
  end

endmodule

`default_nettype wire

// ==== snes_bus_pkg.sv ====
`default_nettype none

package snes_bus_pkg;

  typedef logic [23:0] snes_addr_t;

  // pulses are one CLK2 cycle wide, levels are filtered copies of the pins
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;   // cpu_clk rising
    logic pulse_end;     // bus cycle over, no read or write pending
    logic read;          // active low
    logic write;         // active low
    logic cpu_clk;
    logic romsel;        // active low
  } snes_evt_t;

  typedef enum logic [1:0] {
    lorom = 2'd0,
    hirom = 2'd1
  } mapper_e;

  typedef struct packed {
    mapper_e    mapper;
    snes_addr_t rom_mask;
    snes_addr_t saveram_mask;
  } map_cfg_t;

  typedef struct packed {
    snes_addr_t addr;        // address on the ROM/PSRAM side
    logic       rom_hit;
    logic       is_rom;
    logic       is_saveram;
  } map_res_t;

endpackage

`default_nettype wire

// ==== snes_bus_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module snes_bus_sampler import snes_bus_pkg::*; (
  input  wire             CLK2,
  input  wire             SNES_reset_strobe,
  input  wire snes_addr_t snes_addr_in,
  input  wire             snes_read_in,
  input  wire             snes_write_in,
  input  wire             snes_romsel_in,
  input  wire             snes_cpu_clk_in,
  input  wire [7:0]       snes_data_in,
  output snes_evt_t       evt,
  output snes_addr_t      snes_addr,
  output logic [7:0]      snes_data
);

  logic [3:0]       ctl_s1;   // {cpu_clk, romsel, write, read}
  logic [3:0]       ctl_s2;
  logic             pulse_in;
  logic [7:0]       read_hist;
  logic [7:0]       write_hist;
  logic [7:0]       romsel_hist;
  logic [7:0]       clk_hist;
  logic [7:0]       pulse_hist;
  snes_addr_t       addr_s1;
  snes_addr_t       addr_s2;
  snes_addr_t [1:0] addr_hist;
  logic [7:0]       data_s1;
  logic [7:0]       data_s2;
  logic [1:0][7:0]  data_hist;

  // high while the bus is idle in the address phase
  assign pulse_in = ctl_s2[0] & ctl_s2[1] & ~ctl_s2[3];

  ////////////////////////////////////////
  // control pins
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      ctl_s1      <= 4'b0111;
      ctl_s2      <= 4'b0111;
      read_hist   <= '1;
      write_hist  <= '1;
      romsel_hist <= '1;
      clk_hist    <= '0;
      pulse_hist  <= '1;
    end else begin
      ctl_s1      <= {snes_cpu_clk_in, snes_romsel_in, snes_write_in, snes_read_in};
      ctl_s2      <= ctl_s1;
      read_hist   <= {read_hist[6:0], ctl_s2[0]};
      write_hist  <= {write_hist[6:0], ctl_s2[1]};
      romsel_hist <= {romsel_hist[6:0], ctl_s2[2]};
      clk_hist    <= {clk_hist[6:0], ctl_s2[3]};
      pulse_hist  <= {pulse_hist[6:0], pulse_in};
    end
  end

  // address and data, no reset needed
  always_ff @(posedge CLK2) begin
    addr_s1   <= snes_addr_in;
    addr_s2   <= addr_s1;
    addr_hist <= {addr_hist[0], addr_s2};
    data_s1   <= snes_data_in;
    data_s2   <= data_s1;
    data_hist <= {data_hist[0], data_s2};
  end

  ////////////////////////////////////////
  // edge patterns
  // six stable samples, then two of the new level
  always_comb begin
    evt.rd_start    = (read_hist == 8'b11111100);
    evt.rd_end      = (read_hist == 8'b00000011);
    evt.wr_end      = (write_hist == 8'b00000011);
    evt.cycle_start = (clk_hist == 8'b00000011);
    evt.pulse_end   = (pulse_hist == 8'b00000011);
    evt.read        = read_hist[2] & read_hist[1];
    evt.write       = write_hist[2] & write_hist[1];
    evt.cpu_clk     = clk_hist[2] & clk_hist[1];
    evt.romsel      = romsel_hist[2] & romsel_hist[1];
  end

  assign snes_addr = addr_hist[1] & addr_hist[0]; // kills one-sample glitches
  assign snes_data = data_hist[1] & data_hist[0];

endmodule

`default_nettype wire

// ==== snes_mem_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module snes_mem_ctrl import snes_bus_pkg::*, mem_pkg::*; #(
  parameter int rom_cycle_len = 7
) (
  input  wire             CLK2,
  input  wire             SNES_reset_strobe,
  input  wire map_cfg_t   cfg,
  // console bus
  input  wire snes_addr_t snes_addr_in,
  input  wire             snes_read_in,
  input  wire             snes_write_in,
  input  wire             snes_romsel_in,
  input  wire             snes_cpu_clk_in,
  input  wire [7:0]       snes_data_in,
  output logic [7:0]      snes_data_out,
  output logic            snes_databus_oe,
  output logic            snes_databus_dir,
  // ROM / PSRAM bus
  output logic [22:0]     rom_addr,
  output logic            rom_bhe,
  output logic            rom_ble,
  output logic            rom_we,
  output logic [15:0]     rom_data_out,
  output logic            rom_data_oe,
  input  wire [15:0]      rom_data_in,
  // requesters
  input  wire mem_req_t   mcu_req,
  output logic            mcu_rdy,
  output logic [7:0]      mcu_rdata,
  input  wire mem_req_t   dma_req,
  output logic            dma_rdy,
  output logic [15:0]     dma_rdata
);

  snes_evt_t  evt;
  snes_addr_t filt_addr;
  logic [7:0] filt_data;
  map_res_t   map_res;
  mem_grant_t grant;
  logic [7:0] rom_byte;
  logic [15:0] rom_word;

  snes_bus_sampler u_sampler (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .snes_addr_in      (snes_addr_in),
    .snes_read_in      (snes_read_in),
    .snes_write_in     (snes_write_in),
    .snes_romsel_in    (snes_romsel_in),
    .snes_cpu_clk_in   (snes_cpu_clk_in),
    .snes_data_in      (snes_data_in),
    .evt               (evt),
    .snes_addr         (filt_addr),
    .snes_data         (filt_data)
  );

  snes_addr_map u_map (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .cfg               (cfg),
    .snes_addr         (filt_addr),
    .romsel            (evt.romsel),
    .res               (map_res)
  );

  rom_arbiter #(
    .rom_cycle_len (rom_cycle_len)
  ) u_arb (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .evt               (evt),
    .rom_hit           (map_res.rom_hit),
    .mcu_req           (mcu_req),
    .dma_req           (dma_req),
    .rom_byte          (rom_byte),
    .rom_word          (rom_word),
    .mcu_rdy           (mcu_rdy),
    .mcu_rdata         (mcu_rdata),
    .dma_rdy           (dma_rdy),
    .dma_rdata         (dma_rdata),
    .grant             (grant)
  );

  rom_bus_drive u_drive (
    .grant            (grant),
    .map              (map_res),
    .evt              (evt),
    .snes_data        (filt_data),
    .rom_data_in      (rom_data_in),
    .rom_addr         (rom_addr),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .rom_we           (rom_we),
    .rom_data_out     (rom_data_out),
    .rom_data_oe      (rom_data_oe),
    .rom_byte         (rom_byte),
    .rom_word         (rom_word),
    .snes_data_out    (snes_data_out),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

`default_nettype wire

// ==== tb_snes_mem_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_snes_mem_ctrl import snes_bus_pkg::*, mem_pkg::*; ();

  localparam int num_tests   = 8;
  localparam int cycle_limit = num_tests * 2000;
  localparam int phase       = 12;        // clocks per console phase
  localparam int k_idle      = 0;
  localparam int k_read      = 1;
  localparam int k_write     = 2;
  localparam logic [23:0] rom_size_mask  = 24'h0fffff;
  localparam logic [23:0] save_size_mask = 24'h007fff;

  logic        CLK2;
  logic        SNES_reset_strobe;
  map_cfg_t    cfg;
  snes_addr_t  snes_addr_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in;
  logic [7:0]  snes_data_in;
  logic [7:0]  snes_data_out;
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  logic [22:0] rom_addr;
  logic        rom_bhe;
  logic        rom_ble;
  logic        rom_we;
  logic [15:0] rom_data_out;
  logic        rom_data_oe;
  logic [15:0] rom_data_in;
  mem_req_t    mcu_req;
  logic        mcu_rdy;
  logic [7:0]  mcu_rdata;
  mem_req_t    dma_req;
  logic        dma_rdy;
  logic [15:0] dma_rdata;

  logic [15:0] mem [0:65535];   // PSRAM words, folded index
  integer      seed;
  snes_evt_t   bus_evt;
  string       test_name;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_clean;
  int          err_mark;
  int          cycles;
  int          mcu_at;
  int          dma_at;
  int          n;
  logic        rd_armed = 1'b0;
  logic        rd_seen = 1'b0;
  logic        idle_run = 1'b0;
  logic        idle_active = 1'b0;
  logic [22:0] exp_addr;
  logic [7:0]  exp_byte;
  logic [31:0] ref_res;
  logic [7:0]  byte_d;
  logic [15:0] word_d;
  mem_req_t    req;

  snes_mem_ctrl uut (.*);

  assign bus_evt = uut.evt;

  initial begin
    CLK2 = 1'b0;
    forever #2 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////
  // PSRAM model
  function automatic logic [15:0] mem_idx(input logic [22:0] wa);
    return wa[15:0] ^ {wa[22:16], 9'b0};  // every address bit lands in the index
  endfunction

  assign rom_data_in = mem[mem_idx(rom_addr)];

  // lane enables are active low
  always @(negedge CLK2) begin
    if (!rom_we) begin
      if (!rom_ble) begin
        mem[mem_idx(rom_addr)][7:0] <= rom_data_out[7:0];
      end
      if (!rom_bhe) begin
        mem[mem_idx(rom_addr)][15:8] <= rom_data_out[15:8];
      end
    end
  end

  ////////////////////////////////////////
  // expected ROM address and console byte for a SNES address
  function automatic logic [31:0] ref_map(input logic hi, input logic [23:0] a);
    logic [7:0]  bank;
    logic        save;
    logic [23:0] ra;
    logic [15:0] w;
    bank = a[23:16];
    if (!hi) begin
      save = (bank >= 8'h70) && (bank <= 8'h7d) && !a[15];
    end else begin
      save = ((bank >= 8'h20 && bank <= 8'h3f) || (bank >= 8'ha0 && bank <= 8'hbf))
             && (a[15:0] >= 16'h6000) && (a[15:0] < 16'h8000);
    end
    if (save) begin
      ra = hi ? {6'b0, bank[4:0], a[12:0]} : {4'b0, bank[4:0], a[14:0]};
      ra = 24'he00000 + (ra & save_size_mask);
    end else begin
      ra = hi ? {2'b0, a[21:0]} : {2'b0, bank[6:0], a[14:0]};
      ra = ra & rom_size_mask;
    end
    w = mem[mem_idx(ra[23:1])];
    return {(ra[0] ? w[7:0] : w[15:8]), ra};  // odd byte in the low lane
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test;
    tests_run++;
    if (errors == err_mark) begin
      tests_clean++;
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, errors - err_mark);
    end
  endtask

  // one console cycle, address phase then data phase, then hold
  task automatic bus_cycle(input int kind, input logic [23:0] a, input logic [7:0] d,
                           input logic romsel);
    @(posedge CLK2);
    snes_cpu_clk_in <= 1'b0;
    snes_addr_in    <= a;
    snes_romsel_in  <= romsel;
    snes_data_in    <= d;
    repeat (phase) @(posedge CLK2);
    snes_cpu_clk_in <= 1'b1;
    snes_read_in    <= (kind != k_read);
    snes_write_in   <= (kind != k_write);
    repeat (phase) @(posedge CLK2);
    snes_cpu_clk_in <= 1'b0;
    snes_read_in    <= 1'b1;
    snes_write_in   <= 1'b1;
    repeat (phase) @(posedge CLK2);  // address held so the end events still see it
  endtask

  task automatic console_read(input logic [23:0] a, input logic [22:0] ea,
                              input logic [7:0] eb);
    exp_addr = ea;
    exp_byte = eb;
    rd_seen  = 1'b0;
    rd_armed = 1'b1;
    bus_cycle(k_read, a, 8'h00, 1'b0);
    rd_armed = 1'b0;
    checks++;
    assert (rd_seen) else begin
      $display("%s: the console read cycle produced no read end event", test_name);
      errors++;
    end
  endtask

  task automatic requester_access(input logic dma, input logic wr, input logic [23:0] a,
                                  input logic [15:0] d, input logic word);
    mem_req_t r;
    r      = '0;
    r.rrq  = ~wr;
    r.wrq  = wr;
    r.addr = a;
    r.data = d;
    r.word = word;
    @(posedge CLK2);
    if (dma) begin
      dma_req <= r;
    end else begin
      mcu_req <= r;
    end
    @(posedge CLK2);
    mcu_req <= '0;
    dma_req <= '0;
    do begin
      @(negedge CLK2);
    end while (dma ? !dma_rdy : !mcu_rdy);
  endtask

  // console read results, sampled mid-cycle on rd_end
  always @(negedge CLK2) begin
    if (rd_armed && bus_evt.rd_end) begin
      compare_value("rom_addr", exp_addr, rom_addr);
      compare_value("snes_data_out", exp_byte, snes_data_out);
      compare_value("snes_databus_oe", 0, snes_databus_oe);
      compare_value("snes_databus_dir", 1, snes_databus_dir);
      rd_armed = 1'b0;
      rd_seen  = 1'b1;
    end
  end

  // idle console cycles give the requesters their free slots
  initial begin
    forever begin
      wait (idle_run);
      idle_active = 1'b1;
      bus_cycle(k_idle, 24'h002100, 8'h00, 1'b1);
      idle_active = 1'b0;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge CLK2);
      cycles++;
    end
    $display("run stopped after %0d cycles, test %s never finished", cycles, test_name);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  initial begin
    seed              = 32'h5710_4d7f;
    SNES_reset_strobe = 1'b1;
    cfg.mapper        = lorom;
    cfg.rom_mask      = rom_size_mask;
    cfg.saveram_mask  = save_size_mask;
    snes_addr_in      = '0;
    snes_read_in      = 1'b1;
    snes_write_in     = 1'b1;
    snes_romsel_in    = 1'b1;
    snes_cpu_clk_in   = 1'b0;
    snes_data_in      = '0;
    mcu_req           = '0;
    dma_req           = '0;
    errors            = 0;
    checks            = 0;
    tests_run         = 0;
    tests_clean       = 0;
    test_name         = "reset";
    for (int i = 0; i < 65536; i++) begin
      mem[i] = $random(seed);
    end
    repeat (4) @(posedge CLK2);
    SNES_reset_strobe <= 1'b0;
    @(negedge CLK2);

    start_test("reset");
    compare_value("mcu_rdy", 1, mcu_rdy);
    compare_value("dma_rdy", 1, dma_rdy);
    compare_value("rom_we", 1, rom_we);
    compare_value("rom_data_oe", 0, rom_data_oe);
    compare_value("snes_databus_oe", 1, snes_databus_oe);
    end_test;

    start_test("lorom_rom_read");
    ref_res = ref_map(1'b0, 24'h85abcd);
    console_read(24'h85abcd, ref_res[23:1], ref_res[31:24]);
    end_test;

    @(posedge CLK2);
    cfg.mapper <= hirom;
    start_test("hirom_rom_read");
    ref_res = ref_map(1'b1, 24'hc31234);
    console_read(24'hc31234, ref_res[23:1], ref_res[31:24]);
    end_test;

    idle_run = 1'b1;
    start_test("mcu_byte_write_read");
    byte_d = $random(seed);
    requester_access(1'b0, 1'b1, 24'h012345, {8'h00, byte_d}, 1'b0);
    requester_access(1'b0, 1'b0, 24'h012345, 16'h0000, 1'b0);
    compare_value("mcu_rdata", byte_d, mcu_rdata);
    end_test;

    start_test("dma_word_even");
    word_d = $random(seed);
    requester_access(1'b1, 1'b1, 24'h020200, word_d, 1'b1);
    requester_access(1'b1, 1'b0, 24'h020200, 16'h0000, 1'b1);
    compare_value("dma_rdata", word_d, dma_rdata);
    end_test;

    start_test("dma_word_odd");
    word_d = $random(seed);
    requester_access(1'b1, 1'b1, 24'h020411, word_d, 1'b1);
    requester_access(1'b1, 1'b0, 24'h020411, 16'h0000, 1'b1);
    // odd read passes the word unswapped, so the write swap stays
    compare_value("dma_rdata", {word_d[7:0], word_d[15:8]}, dma_rdata);
    end_test;

    start_test("mcu_before_dma");
    req      = '0;
    req.rrq  = 1'b1;
    req.addr = 24'h012345;
    @(posedge CLK2);
    mcu_req  <= req;
    req.addr = 24'h020200;
    req.word = 1'b1;
    dma_req  <= req;
    @(posedge CLK2);
    mcu_req <= '0;
    dma_req <= '0;
    mcu_at  = 0;
    dma_at  = 0;
    n       = 0;
    while (mcu_at == 0 || dma_at == 0) begin
      @(negedge CLK2);
      n++;
      if (mcu_rdy && mcu_at == 0) mcu_at = n;
      if (dma_rdy && dma_at == 0) dma_at = n;
    end
    checks++;
    assert (mcu_at < dma_at) else begin
      $display("%s: dma_rdy rose at cycle %0d, not after mcu_rdy at cycle %0d",
               test_name, dma_at, mcu_at);
      errors++;
    end
    compare_value("mcu_rdata", byte_d, mcu_rdata);
    end_test;
    idle_run = 1'b0;
    wait (!idle_active);

    @(posedge CLK2);
    cfg.mapper <= lorom;
    start_test("saveram_write_read");
    byte_d = $random(seed);
    bus_cycle(k_write, 24'h701234, byte_d, 1'b0);
    ref_res = ref_map(1'b0, 24'h701234);
    compare_value("stored byte", byte_d, ref_res[31:24]);
    console_read(24'h701234, ref_res[23:1], byte_d);
    end_test;

    $display("%0d of %0d tests clean, %0d checks, %0d errors",
             tests_clean, tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
